/* source/ow_defs.svh */
//--------------------------------------------------------------------
// one-wire bus timing in microseconds, clock rate, command bytes
// and the number of scratchpad bits read per round
//--------------------------------------------------------------------
`ifndef OW_DEFS_SVH
`define OW_DEFS_SVH

`define OW_CLKS_PER_US        1       // 1 MHz system clock

`define OW_RESET_LOW_US       500
`define OW_PRESENCE_SAMPLE_US 100     // release to presence sample
`define OW_RESET_RECOVER_US   400
`define OW_SLOT_US            80      // whole write slot
`define OW_WRITE1_LOW_US      1
`define OW_READ_SAMPLE_US     10      // release to read sample
`define OW_READ_RECOVER_US    55
`define OW_CONV_TIMEOUT_US    750000  // worst case 12-bit conversion

`define OW_CMD_SKIP_ROM       8'hCC
`define OW_CMD_CONVERT        8'h44
`define OW_CMD_READ_PAD       8'hBE

`define OW_READ_BITS          16

`endif

/* source/ow_pkg.sv */
//--------------------------------------------------------------------
// shared types for the one-wire temperature reader
//--------------------------------------------------------------------
package ow_pkg;

  typedef logic [15:0] temp_raw_t;   // two's complement, 1/16 degC
  typedef logic [15:0] temp_bcd_t;   // sign, tens, units, tenths
  typedef logic [7:0]  ow_byte_t;
  typedef logic [19:0] us_count_t;   // wide enough for the 750 ms timeout

  typedef enum logic [1:0] {
    SLOT_RESET,
    SLOT_WRITE0,
    SLOT_WRITE1,
    SLOT_READ
  } slot_op_t;

  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_LOW,       // master holds the bus low
    SLOT_SAMPLE,    // released, waiting for the sample point
    SLOT_RECOVER
  } slot_state_t;

  typedef enum logic [2:0] {
    SEQ_RESET, SEQ_RESET_WAIT, SEQ_LOAD, SEQ_WRITE,
    SEQ_WRITE_WAIT, SEQ_CONVERT, SEQ_READ, SEQ_READ_WAIT
  } seq_state_t;

endpackage

/* source/ow_slot_engine.sv */
//--------------------------------------------------------------------
// one-wire slot engine
// runs one reset, write-0, write-1 or read slot per request and
// returns the sampled bus level
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "ow_defs.svh"

module ow_slot_engine
  import ow_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     slot_start,
  input  slot_op_t slot_op,
  input  logic     ow_sense,
  output logic     ow_drive_low,
  output logic     slot_done,
  output logic     slot_bit
);

  // phase lengths in clock cycles
  localparam us_count_t RST_LOW  = us_count_t'(`OW_RESET_LOW_US * `OW_CLKS_PER_US);
  localparam us_count_t RST_SMP  = us_count_t'(`OW_PRESENCE_SAMPLE_US * `OW_CLKS_PER_US);
  localparam us_count_t RST_REC  = us_count_t'(`OW_RESET_RECOVER_US * `OW_CLKS_PER_US);
  localparam us_count_t W0_LOW   = us_count_t'(`OW_SLOT_US * `OW_CLKS_PER_US);
  localparam us_count_t W1_LOW   = us_count_t'(`OW_WRITE1_LOW_US * `OW_CLKS_PER_US);
  localparam us_count_t W1_REC   =
    us_count_t'((`OW_SLOT_US - `OW_WRITE1_LOW_US) * `OW_CLKS_PER_US);
  localparam us_count_t RD_SMP   = us_count_t'(`OW_READ_SAMPLE_US * `OW_CLKS_PER_US);
  localparam us_count_t RD_REC   = us_count_t'(`OW_READ_RECOVER_US * `OW_CLKS_PER_US);

  slot_state_t state;
  slot_op_t    op_q;
  us_count_t   timer;
  us_count_t   low_len;
  us_count_t   smp_len;
  us_count_t   rec_len;
  logic        has_sample;

  //------------------------------------------------------------------
  // per-slot phase table
  //------------------------------------------------------------------
  always_comb
  begin
    has_sample = 1'b0;
    smp_len    = us_count_t'(1);
    case (op_q)
      SLOT_RESET:
      begin
        low_len    = RST_LOW;
        smp_len    = RST_SMP;            // presence sample
        rec_len    = RST_REC;
        has_sample = 1'b1;
      end
      SLOT_WRITE0:
      begin
        low_len = W0_LOW;
        rec_len = us_count_t'(1);        // one released cycle
      end
      SLOT_WRITE1:
      begin
        low_len = W1_LOW;
        rec_len = W1_REC;
      end
      default:
      begin
        low_len    = W1_LOW;             // read opens like a write 1
        smp_len    = RD_SMP;
        rec_len    = RD_REC;
        has_sample = 1'b1;
      end
    endcase
  end

  //------------------------------------------------------------------
  // slot FSM
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= SLOT_IDLE;
      op_q         <= SLOT_RESET;
      timer        <= '0;
      ow_drive_low <= 1'b0;
      slot_done    <= 1'b0;
      slot_bit     <= 1'b1;
    end
    else
    begin
      slot_done <= 1'b0;
      case (state)
        SLOT_IDLE:
        begin
          if (slot_start)
          begin
            op_q         <= slot_op;
            timer        <= '0;
            ow_drive_low <= 1'b1;      // every slot starts with a falling edge
            state        <= SLOT_LOW;
          end
        end
        SLOT_LOW:
        begin
          timer <= timer + 1'b1;
          if (timer == low_len - 1'b1)
          begin
            ow_drive_low <= 1'b0;
            timer        <= '0;
            state        <= has_sample ? SLOT_SAMPLE : SLOT_RECOVER;
          end
        end
        SLOT_SAMPLE:
        begin
          timer <= timer + 1'b1;
          if (timer == smp_len - 1'b1)
          begin
            slot_bit <= ow_sense;        // 0 = presence or read 0
            timer    <= '0;
            state    <= SLOT_RECOVER;
          end
        end
        SLOT_RECOVER:
        begin
          timer <= timer + 1'b1;
          if (timer == rec_len - 1'b1)
          begin
            slot_done <= 1'b1;
            state     <= SLOT_IDLE;
          end
        end
        default: state <= SLOT_IDLE;
      endcase
    end
  end

endmodule

/* source/ow_sequencer.sv */
//--------------------------------------------------------------------
// one-wire round sequencer
// reset, skip-rom, convert, wait, reset, skip-rom, read scratchpad,
// then 16 reading bits, one slot request at a time
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "ow_defs.svh"

module ow_sequencer
  import ow_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      slot_done,
  input  logic      slot_bit,
  input  logic      ow_sense,
  output logic      slot_start,
  output slot_op_t  slot_op,
  output logic      raw_valid,
  output temp_raw_t raw_temp
);

  localparam us_count_t  CONV_LAST =
    us_count_t'(`OW_CONV_TIMEOUT_US * `OW_CLKS_PER_US - 1);
  localparam logic [3:0] READ_LAST = 4'(`OW_READ_BITS - 1);

  seq_state_t state;
  logic [1:0] cmd_idx;      // 0 skip, 1 convert, 2 skip, 3 read pad
  ow_byte_t   cmd_next;
  ow_byte_t   cmd_shift;
  logic [3:0] bit_cnt;
  us_count_t  conv_timer;

  always_comb
  begin
    case (cmd_idx)
      2'd1:    cmd_next = `OW_CMD_CONVERT;
      2'd3:    cmd_next = `OW_CMD_READ_PAD;
      default: cmd_next = `OW_CMD_SKIP_ROM;
    endcase
  end

  //------------------------------------------------------------------
  // round FSM
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= SEQ_RESET;
      cmd_idx    <= 2'd0;
      bit_cnt    <= '0;
      conv_timer <= '0;
      slot_start <= 1'b0;
      slot_op    <= SLOT_RESET;
      raw_valid  <= 1'b0;
    end
    else
    begin
      slot_start <= 1'b0;
      raw_valid  <= 1'b0;
      case (state)
        SEQ_RESET:
        begin
          slot_start <= 1'b1;
          slot_op    <= SLOT_RESET;
          state      <= SEQ_RESET_WAIT;
        end
        SEQ_RESET_WAIT:
          if (slot_done)
            state <= slot_bit ? SEQ_RESET : SEQ_LOAD;   // no presence, retry
        SEQ_LOAD:
        begin
          bit_cnt <= '0;
          state   <= SEQ_WRITE;
        end
        SEQ_WRITE:
        begin
          slot_start <= 1'b1;
          slot_op    <= cmd_shift[0] ? SLOT_WRITE1 : SLOT_WRITE0;  // lsb first
          state      <= SEQ_WRITE_WAIT;
        end
        SEQ_WRITE_WAIT:
        begin
          if (slot_done)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            state   <= SEQ_WRITE;
            if (bit_cnt == 4'd7)
            begin
              bit_cnt    <= '0;
              conv_timer <= '0;
              cmd_idx    <= cmd_idx + 1'b1;
              case (cmd_idx)
                2'd1:    state <= SEQ_CONVERT;
                2'd3:    state <= SEQ_READ;
                default: state <= SEQ_LOAD;
              endcase
            end
          end
        end
        SEQ_CONVERT:
        begin
          conv_timer <= conv_timer + 1'b1;
          if (ow_sense || conv_timer == CONV_LAST)   // sensor releases when done
            state <= SEQ_RESET;
        end
        SEQ_READ:
        begin
          slot_start <= 1'b1;
          slot_op    <= SLOT_READ;
          state      <= SEQ_READ_WAIT;
        end
        SEQ_READ_WAIT:
        begin
          if (slot_done)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            state   <= SEQ_READ;
            if (bit_cnt == READ_LAST)
            begin
              raw_valid <= 1'b1;
              state     <= SEQ_RESET;        // next round right away
            end
          end
        end
        default: state <= SEQ_RESET;
      endcase
    end
  end

  // command and reading shift registers
  always_ff @(posedge clk)
  begin
    if (state == SEQ_LOAD)
      cmd_shift <= cmd_next;
    else if (state == SEQ_WRITE_WAIT && slot_done)
      cmd_shift <= cmd_shift >> 1;
    if (state == SEQ_READ_WAIT && slot_done)
      raw_temp <= {slot_bit, raw_temp[15:1]};    // lsb arrives first
  end

endmodule

/* source/temp_decode.sv */
//--------------------------------------------------------------------
// raw reading to sign, tens, units and tenths nibbles
//--------------------------------------------------------------------
`timescale 1ns/10ps

module temp_decode
  import ow_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      raw_valid,
  input  temp_raw_t raw_temp,
  output logic      temp_valid,
  output temp_bcd_t temp_bcd
);

  logic [6:0] int_part;     // whole degrees left by the 0x07ff mask
  logic [7:0] frac_x10;
  logic [3:0] sign_nib;
  logic [3:0] tens;
  logic [3:0] units;
  logic [3:0] tenths;

  always_comb
  begin
    int_part = raw_temp[10:4];
    frac_x10 = {4'b0000, raw_temp[3:0]} * 8'd10;
    sign_nib = {3'b000, raw_temp[15]};      // 1 = below zero
    tens     = 4'(int_part / 7'd10);
    units    = 4'(int_part % 7'd10);
    tenths   = frac_x10[7:4];               // (frac * 10) >> 4
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      temp_valid <= 1'b0;
    else
      temp_valid <= raw_valid;
  end

  // result held until the next reading
  always_ff @(posedge clk)
  begin
    if (raw_valid)
      temp_bcd <= {sign_nib, tens, units, tenths};
  end

endmodule

/* source/ds18_temp_top.sv */
//--------------------------------------------------------------------
// one-wire temperature reader top
// sequencer -> slot engine on the bus, sequencer -> decode
//--------------------------------------------------------------------
`timescale 1ns/10ps

module ds18_temp_top
  import ow_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ow_sense,       // resolved bus level
  output logic      ow_drive_low,   // open drain pull-down
  output logic      temp_valid,
  output temp_bcd_t temp_bcd
);

  logic      slot_start;
  slot_op_t  slot_op;
  logic      slot_done;
  logic      slot_bit;
  logic      raw_valid;
  temp_raw_t raw_temp;

  ow_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .slot_done  (slot_done),
    .slot_bit   (slot_bit),
    .ow_sense   (ow_sense),
    .slot_start (slot_start),
    .slot_op    (slot_op),
    .raw_valid  (raw_valid),
    .raw_temp   (raw_temp)
  );

  ow_slot_engine u_slot_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .slot_start   (slot_start),
    .slot_op      (slot_op),
    .ow_sense     (ow_sense),
    .ow_drive_low (ow_drive_low),
    .slot_done    (slot_done),
    .slot_bit     (slot_bit)
  );

  temp_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .raw_valid  (raw_valid),
    .raw_temp   (raw_temp),
    .temp_valid (temp_valid),
    .temp_bcd   (temp_bcd)
  );

endmodule

/* tb/ds18_temp_assert.sv */
//--------------------------------------------------------------------
// concurrent assertions on the reader's top-level ports
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "ow_defs.svh"

module ds18_temp_assert (
  input logic clk,
  input logic rst_n,
  input logic ow_drive_low,
  input logic temp_valid
);

  localparam int RESET_LEN = `OW_RESET_LOW_US * `OW_CLKS_PER_US;

  int low_run;   // consecutive cycles with the bus pulled low

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      low_run <= 0;
    else if (ow_drive_low)
      low_run <= low_run + 1;
    else
      low_run <= 0;
  end

  a_released_in_reset: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> !ow_drive_low)
    else $error("bus pulled low during or right after reset");

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    temp_valid |=> !temp_valid)
    else $error("temp_valid high on two cycles in a row");

  a_low_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    low_run <= RESET_LEN)
    else $error("bus held low longer than a reset pulse");

endmodule

/* tb/ds18_sensor_model.sv */
//--------------------------------------------------------------------
// behavioral one-wire temperature sensor
// presence pulse, command byte decoding, conversion hold and
// scratchpad bit replies
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "ow_defs.svh"

module ds18_sensor_model
  import ow_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      master_low,     // the DUT's pull-down
  input  temp_raw_t reading,
  input  int        hold_cycles,
  input  logic      silent,         // ignore one reset this round
  output logic      pull_low,
  output logic      byte_valid,
  output ow_byte_t  byte_data,
  output logic      converting,
  output logic      reply_done,
  output logic      skipped
);

  localparam int RESET_MIN = `OW_RESET_LOW_US * `OW_CLKS_PER_US / 2;
  localparam int ZERO_MIN  = `OW_SLOT_US * `OW_CLKS_PER_US / 2;

  logic       last_low;
  logic       read_phase;
  logic       silence_used;
  logic       unselected;    // no presence given, deaf until the next reset
  logic [3:0] bit_cnt;
  logic [4:0] rd_cnt;
  ow_byte_t   shift;
  int         low_len;
  int         pres_cnt;      // counts down from release of a reset
  int         pull_cnt;      // read-0 reply or conversion hold

  // all updates land 1 ns after the rising edge
  always @(posedge clk)
  begin
    #1;
    byte_valid = 1'b0;
    reply_done = 1'b0;
    skipped    = 1'b0;
    if (!rst_n)
    begin
      last_low     = 1'b0;
      read_phase   = 1'b0;
      silence_used = 1'b0;
      unselected   = 1'b0;
      converting   = 1'b0;
      bit_cnt      = 4'd0;
      rd_cnt       = 5'd0;
      shift        = 8'h00;
      byte_data    = 8'h00;
      low_len      = 0;
      pres_cnt     = 0;
      pull_cnt     = 0;
    end
    else
    begin
      if (pull_cnt > 0)
        pull_cnt = pull_cnt - 1;
      else
        converting = 1'b0;
      if (pres_cnt > 0)
        pres_cnt = pres_cnt - 1;
      if (master_low && !last_low && read_phase)
      begin
        if (!reading[rd_cnt[3:0]])
          pull_cnt = 30;                    // hold past the read sample
        rd_cnt = rd_cnt + 5'd1;
      end
      if (master_low)
        low_len = low_len + 1;
      else if (last_low)
      begin
        if (low_len >= RESET_MIN)
        begin
          bit_cnt    = 4'd0;
          read_phase = 1'b0;
          if (silent && !silence_used)
          begin
            silence_used = 1'b1;
            skipped      = 1'b1;
            unselected   = 1'b1;
          end
          else
          begin
            unselected = 1'b0;
            pres_cnt   = 140;
          end
        end
        else if (read_phase)
        begin
          if (rd_cnt == 5'(`OW_READ_BITS))
          begin
            read_phase   = 1'b0;
            silence_used = 1'b0;
            reply_done   = 1'b1;
          end
        end
        else if (!unselected)
        begin
          shift   = {low_len < ZERO_MIN, shift[7:1]};   // lsb first
          bit_cnt = bit_cnt + 4'd1;
          if (bit_cnt == 4'd8)
          begin
            bit_cnt    = 4'd0;
            byte_valid = 1'b1;
            byte_data  = shift;
            if (shift == `OW_CMD_CONVERT)
            begin
              converting = 1'b1;
              pull_cnt   = hold_cycles;
            end
            else if (shift == `OW_CMD_READ_PAD)
            begin
              read_phase = 1'b1;
              rd_cnt     = 5'd0;
            end
          end
        end
        low_len = 0;
      end
      last_low = master_low;
    end
    // presence from 20 to 140 cycles after release
    pull_low = converting || pull_cnt > 0 || (pres_cnt > 0 && pres_cnt <= 120);
  end

endmodule

/* tb/ds18_temp_tb.sv */
//--------------------------------------------------------------------
// testbench for the one-wire temperature reader
// clock, reset, wired-AND bus, sensor model, random rounds from an
// LCG, reference decode and compare tasks
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "ow_defs.svh"

module ds18_temp_tb
  import ow_pkg::*;
();

  localparam int ROUNDS      = 12;
  localparam int ROUND_LIMIT = 20000;   // cycles, covers a silent retry

  logic      clk = 1'b0;
  logic      rst_n;
  logic      ow_sense;
  logic      ow_drive_low;
  logic      temp_valid;
  temp_bcd_t temp_bcd;

  logic      sensor_pull;
  temp_raw_t reading;
  int        hold_cycles;
  logic      silent;
  logic      byte_valid;
  ow_byte_t  byte_data;
  logic      converting;
  logic      reply_done;
  logic      skipped;

  logic [31:0] lcg_state = 32'd45;
  int          cmd_pos   = 0;
  int          reads_sent = 0;
  int          skip_seen = 0;

  always #4 clk = ~clk;

  // open drain bus, released unless someone pulls
  assign ow_sense = !(ow_drive_low === 1'b1 || sensor_pull === 1'b1);

  ds18_temp_top u_ds18_temp_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .ow_sense     (ow_sense),
    .ow_drive_low (ow_drive_low),
    .temp_valid   (temp_valid),
    .temp_bcd     (temp_bcd)
  );

  ds18_sensor_model u_sensor (
    .clk         (clk),
    .rst_n       (rst_n),
    .master_low  (ow_drive_low),
    .reading     (reading),
    .hold_cycles (hold_cycles),
    .silent      (silent),
    .pull_low    (sensor_pull),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .converting  (converting),
    .reply_done  (reply_done),
    .skipped     (skipped)
  );

  bind ds18_temp_top ds18_temp_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .ow_drive_low (ow_drive_low),
    .temp_valid   (temp_valid)
  );

  //------------------------------------------------------------------
  // helpers
  //------------------------------------------------------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];                 // upper half, better spread
  endfunction

  // sign, then whole degrees from the 0x07ff mask, then tenths
  function automatic temp_bcd_t model_bcd(input temp_raw_t raw);
    int        whole;
    int        frac;
    temp_bcd_t bcd;
    whole      = int'(raw & 16'h07ff) / 16;
    frac       = int'(raw[3:0]) * 10 / 16;
    bcd[15:12] = raw[15] ? 4'd1 : 4'd0;
    bcd[11:8]  = 4'(whole / 10);
    bcd[7:4]   = 4'(whole % 10);
    bcd[3:0]   = 4'(frac);
    return bcd;
  endfunction

  function automatic ow_byte_t expected_cmd(input int idx);
    case (idx)
      1:       return `OW_CMD_CONVERT;
      3:       return `OW_CMD_READ_PAD;
      default: return `OW_CMD_SKIP_ROM;
    endcase
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bcd(input string name, input temp_bcd_t exp, input temp_bcd_t act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_byte(input string name, input ow_byte_t exp, input ow_byte_t act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  //------------------------------------------------------------------
  // bus monitor, sampled mid-cycle
  //------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (converting && ow_drive_low)
        stop_on_error("DUT pulled the bus low while the sensor held a conversion");
      if (byte_valid)
      begin
        check_byte($sformatf("command byte %0d", cmd_pos), expected_cmd(cmd_pos % 4),
                   byte_data);
        cmd_pos++;
      end
      if (reply_done)
        reads_sent++;
      if (skipped)
        skip_seen++;
    end
  end

  //------------------------------------------------------------------
  // rounds
  //------------------------------------------------------------------
  initial
  begin
    int        wait_cnt;
    int        silent_rounds;
    temp_raw_t raw;
    rst_n         = 1'b0;
    reading       = 16'h0000;
    hold_cycles   = 100;
    silent        = 1'b0;
    silent_rounds = 0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int r = 0; r < ROUNDS; r++)
    begin
      raw = lcg_next() & 16'h07ff;
      if (r % 3 == 2)
        raw = raw | 16'hf800;                    // negative reading
      hold_cycles = 50 + int'(lcg_next() % 16'd251);
      silent      = (r == 1) || (lcg_next() % 16'd4 == 16'd0);
      if (silent)
        silent_rounds++;
      reading  = raw;
      wait_cnt = 0;
      do
      begin
        @(posedge clk);
        #1;
        wait_cnt++;
      end
      while (temp_valid !== 1'b1 && wait_cnt < ROUND_LIMIT);
      if (temp_valid !== 1'b1)
        stop_on_error($sformatf("timeout waiting for temp_valid in round %0d", r));
      if (reads_sent != r + 1)
        stop_on_error($sformatf("temp_valid in round %0d without exactly one read", r));
      check_bcd($sformatf("round %0d raw %h", r, raw), model_bcd(raw), temp_bcd);
    end
    if (skip_seen != silent_rounds)
      stop_on_error($sformatf("MISMATCH silent resets expected %0d actual %0d",
                              silent_rounds, skip_seen));
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* all.f */
+incdir+source
source/ow_pkg.sv
source/ow_slot_engine.sv
source/ow_sequencer.sv
source/temp_decode.sv
source/ds18_temp_top.sv
tb/ds18_temp_assert.sv
tb/ds18_sensor_model.sv
tb/ds18_temp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module ds18_temp_tb \
  -o ds18_temp_sim \
  && ./obj_dir/ds18_temp_sim \
  || { echo "ds18_temp: build or simulation failed" >&2; exit 1; }
